// ==== compile.f ====
+incdir+.
ps2_kbd_pkg.sv
ps2_frame_rx.sv
scan_code_decoder.sv
key_slot.sv
key_output_stage.sv
ps2_keyboard_tracker.sv
ps2_keyboard_tracker_asserts.sv
tb_ps2_keyboard_tracker.sv

// ==== Makefile ====
# Verilator build and run of the PS/2 keyboard tracker testbench

VERILATOR ?= verilator
TOP       ?= tb_ps2_keyboard_tracker
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) ps2_kbd_consts.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_ps2_keyboard_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_consts.svh"

module tb_ps2_keyboard_tracker
  import ps2_kbd_pkg::*;
();

  localparam int          HALF_BIT  = 10;
  localparam int          SETTLE    = 4;
  localparam int          FRAME_TMO = 1000;
  localparam int          NUM_ROWS  = 22;
  localparam int          NK        = `PS2_NUM_KEYS;
  localparam logic [31:0] SEED      = 32'h85d6_75a6;
  localparam logic [3:0]  NO_PULSE  = 4'd8;
  localparam logic [63:0] KEY_CODES = `PS2_KEY_CODES;
  localparam key_vec_t    EXT_MASK  = `PS2_KEY_EXTENDED;

  // One stimulus row, n bytes sent as b0, b1, b2
  typedef struct packed {
    logic [1:0] n;
    scan_byte_t b0;
    scan_byte_t b1;
    scan_byte_t b2;
    logic       bad;
    logic       pulse;
    key_vec_t   keys;
    logic [3:0] pidx;
  } row_t;

  logic     CLOCK_50;
  logic     reset;
  logic     ps2_clk;
  logic     ps2_dat;
  logic     pulse_mode;
  key_vec_t o_keys;
  logic     o_frame_error;

  row_t     rows [NUM_ROWS];
  int       order [NK];
  int       errors;
  logic     timed_out;
  int       done_cnt = 0;
  int       done_target;
  int       err_cnt = 0;
  int       err_base;
  int       high_cnt [NK] = '{default: 0};
  int       high_base [NK];
  key_vec_t expect_vec;

  ps2_keyboard_tracker DUT (
    .CLOCK_50      (CLOCK_50),
    .reset         (reset),
    .i_ps2_clk     (ps2_clk),
    .i_ps2_dat     (ps2_dat),
    .i_pulse_mode  (pulse_mode),
    .o_keys        (o_keys),
    .o_frame_error (o_frame_error)
  );

  initial begin
    CLOCK_50 = 1'b0;
    forever #20 CLOCK_50 = ~CLOCK_50;
  end

  // Count finished frames, bad frames and high cycles per key
  // receiver byte strobe marks a good frame
  always @(negedge CLOCK_50) begin
    if (DUT.rx_byte_valid || o_frame_error)
      done_cnt++;
    if (o_frame_error)
      err_cnt++;
    for (int k = 0; k < NK; k++) begin
      if (o_keys[k])
        high_cnt[k]++;
    end
  end

  // Stimulus table, pidx is the key that must pulse in pulse mode
  task automatic build_table();
    rows[0]  = '{2'd1, 8'h1d, 8'h00, 8'h00, 1'b0, 1'b0, 8'h10, NO_PULSE};
    rows[1]  = '{2'd2, 8'he0, 8'h75, 8'h00, 1'b0, 1'b0, 8'h14, NO_PULSE};
    rows[2]  = '{2'd2, 8'he0, 8'h6b, 8'h00, 1'b0, 1'b0, 8'h15, NO_PULSE};
    rows[3]  = '{2'd2, 8'hf0, 8'h1d, 8'h00, 1'b0, 1'b0, 8'h05, NO_PULSE};
    rows[4]  = '{2'd3, 8'he0, 8'hf0, 8'h75, 1'b0, 1'b0, 8'h01, NO_PULSE};
    rows[5]  = '{2'd3, 8'he0, 8'hf0, 8'h6b, 1'b0, 1'b0, 8'h00, NO_PULSE};
    // Bare arrow codes and an untracked key
    rows[6]  = '{2'd1, 8'h74, 8'h00, 8'h00, 1'b0, 1'b0, 8'h00, NO_PULSE};
    rows[7]  = '{2'd1, 8'h6b, 8'h00, 8'h00, 1'b0, 1'b0, 8'h00, NO_PULSE};
    rows[8]  = '{2'd1, 8'h2b, 8'h00, 8'h00, 1'b0, 1'b0, 8'h00, NO_PULSE};
    rows[9]  = '{2'd1, 8'h1c, 8'h00, 8'h00, 1'b0, 1'b0, 8'h20, NO_PULSE};
    // Wrong parity on S, then the same frame sent clean
    rows[10] = '{2'd1, 8'h1b, 8'h00, 8'h00, 1'b1, 1'b0, 8'h20, NO_PULSE};
    rows[11] = '{2'd1, 8'h1b, 8'h00, 8'h00, 1'b0, 1'b0, 8'h60, NO_PULSE};
    rows[12] = '{2'd2, 8'hf0, 8'h1c, 8'h00, 1'b0, 1'b0, 8'h40, NO_PULSE};
    rows[13] = '{2'd2, 8'hf0, 8'h1b, 8'h00, 1'b0, 1'b0, 8'h00, NO_PULSE};
    // Pulse mode, a repeated make while held gives no second pulse
    rows[14] = '{2'd1, 8'h1d, 8'h00, 8'h00, 1'b0, 1'b1, 8'h00, 4'd4};
    rows[15] = '{2'd1, 8'h1d, 8'h00, 8'h00, 1'b0, 1'b1, 8'h00, NO_PULSE};
    rows[16] = '{2'd2, 8'hf0, 8'h1d, 8'h00, 1'b0, 1'b1, 8'h00, NO_PULSE};
    rows[17] = '{2'd2, 8'he0, 8'h72, 8'h00, 1'b0, 1'b1, 8'h00, 4'd3};
    rows[18] = '{2'd1, 8'h23, 8'h00, 8'h00, 1'b1, 1'b1, 8'h00, NO_PULSE};
    rows[19] = '{2'd3, 8'he0, 8'hf0, 8'h72, 1'b0, 1'b1, 8'h00, NO_PULSE};
    rows[20] = '{2'd1, 8'h1d, 8'h00, 8'h00, 1'b0, 1'b1, 8'h00, 4'd4};
    rows[21] = '{2'd2, 8'hf0, 8'h1d, 8'h00, 1'b0, 1'b1, 8'h00, NO_PULSE};
  endtask

  // Start, data LSB first, odd parity, stop
  // data moves while the clock is high, the DUT samples on the fall
  task automatic send_frame(input scan_byte_t data, input logic bad_parity);
    logic [10:0] frame;
    int          t;
    frame       = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
    done_target = done_cnt + 1;
    t           = 0;
    if (!timed_out) begin
      for (int i = 0; i < 11; i++) begin
        @(posedge CLOCK_50);
        ps2_dat <= frame[i];
        repeat (HALF_BIT) @(posedge CLOCK_50);
        ps2_clk <= 1'b0;
        repeat (HALF_BIT) @(posedge CLOCK_50);
        ps2_clk <= 1'b1;
      end
      while (done_cnt < done_target && t < FRAME_TMO) begin
        @(negedge CLOCK_50);
        t++;
      end
      if (done_cnt < done_target) begin
        $display("Timeout, the receiver never finished the frame for byte %h", data);
        timed_out = 1'b1;
      end
    end
  endtask

  // Extended keys get E0 first, breaks get F0 before the code
  task automatic key_event(input int idx, input logic make);
    if (EXT_MASK[idx])
      send_frame(`PS2_CODE_EXTEND, 1'b0);
    if (!make)
      send_frame(`PS2_CODE_BREAK, 1'b0);
    send_frame(KEY_CODES[8*idx +: 8], 1'b0);
  endtask

  // Fisher-Yates over all key indices
  task automatic shuffle_keys();
    int j;
    int tmp;
    for (int i = 0; i < NK; i++)
      order[i] = i;
    for (int i = NK - 1; i > 0; i--) begin
      j        = int'($urandom % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
  endtask

  task automatic check_keys(input key_vec_t exp);
    assert (o_keys == exp) else begin
      errors++;
      $display("Fail o_keys exp %h got %h at %0t", exp, o_keys, $time);
    end
  endtask

  task automatic check_row(input int r);
    int exp_hi;
    int got_hi;
    check_keys(rows[r].keys);
    assert ((err_cnt - err_base) == int'(rows[r].bad)) else begin
      errors++;
      $display("Fail o_frame_error pulses row %0d exp %h got %h",
               r, rows[r].bad, err_cnt - err_base);
    end
    // Pulse mode, exactly one high cycle on the pressed key only
    if (rows[r].pulse) begin
      for (int k = 0; k < NK; k++) begin
        exp_hi = (rows[r].pidx == k) ? 1 : 0;
        got_hi = high_cnt[k] - high_base[k];
        assert (got_hi == exp_hi) else begin
          errors++;
          $display("Fail o_keys[%0d] high cycles row %0d exp %h got %h",
                   k, r, exp_hi, got_hi);
        end
      end
    end
  endtask

  initial begin
    logic [23:0] bytes;
    void'($urandom(SEED));
    errors     = 0;
    timed_out  = 1'b0;
    reset      = 1'b0;
    ps2_clk    = 1'b1;
    ps2_dat    = 1'b1;
    pulse_mode = 1'b0;
    build_table();
    repeat (2) @(posedge CLOCK_50);
    reset <= 1'b1;

    // Outputs straight out of reset
    @(negedge CLOCK_50);
    check_keys('0);
    assert (o_frame_error == 1'b0) else begin
      errors++;
      $display("Fail o_frame_error exp %h got %h after reset", 1'b0, o_frame_error);
    end

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      @(posedge CLOCK_50);
      pulse_mode <= rows[r].pulse;
      err_base  = err_cnt;
      high_base = high_cnt;
      bytes     = {rows[r].b2, rows[r].b1, rows[r].b0};
      // Bad parity goes on the last byte of the row
      for (int b = 0; b < int'(rows[r].n); b++)
        send_frame(bytes[8*b +: 8], rows[r].bad && (b == int'(rows[r].n) - 1));
      repeat (SETTLE) @(negedge CLOCK_50);
      if (!timed_out)
        check_row(r);
    end

    // Hold mode, all keys pressed then released in random order
    @(posedge CLOCK_50);
    pulse_mode <= 1'b0;
    expect_vec = '0;
    for (int pass = 0; pass < 2 && !timed_out; pass++) begin
      shuffle_keys();
      for (int i = 0; i < NK; i++) begin
        key_event(order[i], pass == 0);
        expect_vec[order[i]] = (pass == 0);
        repeat (SETTLE) @(negedge CLOCK_50);
        if (!timed_out)
          check_keys(expect_vec);
      end
    end

    $display("Checks done, %0d errors, %0d timeouts", errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== ps2_keyboard_tracker_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module ps2_keyboard_tracker_asserts
  import ps2_kbd_pkg::*;
(
  input logic     i_clk,
  input logic     i_reset_n,
  input logic     i_pulse_mode,
  input key_vec_t i_keys,
  input logic     i_frame_error
);

  // Synchronous reset, outputs clear on the edge after it is seen
  a_keys_reset: assert property (
    @(posedge i_clk) !i_reset_n |=> (i_keys == '0)
  ) else $error("o_keys not clear in the cycle after reset");

  // Steady pulse mode never keeps a key bit high two cycles running
  a_pulse_single: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_pulse_mode && $past(i_pulse_mode)) |-> ((i_keys & $past(i_keys)) == '0)
  ) else $error("o_keys bit high for two cycles in pulse mode");

  // Frame error is a one cycle strobe
  a_error_pulse: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_frame_error |=> !i_frame_error
  ) else $error("o_frame_error held longer than one cycle");

endmodule

bind ps2_keyboard_tracker ps2_keyboard_tracker_asserts u_asserts (
  .i_clk         (CLOCK_50),
  .i_reset_n     (reset),
  .i_pulse_mode  (i_pulse_mode),
  .i_keys        (o_keys),
  .i_frame_error (o_frame_error)
);

`default_nettype wire

// ==== ps2_keyboard_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_consts.svh"

module ps2_keyboard_tracker
  import ps2_kbd_pkg::*;
(
  input  logic     CLOCK_50,
  input  logic     reset,
  input  logic     i_ps2_clk,
  input  logic     i_ps2_dat,
  input  logic     i_pulse_mode,
  output key_vec_t o_keys,
  output logic     o_frame_error
);

  // Code table and extended mask as indexable constants
  localparam logic [8*`PS2_NUM_KEYS-1:0] KEY_CODES    = `PS2_KEY_CODES;
  localparam key_vec_t                   KEY_EXTENDED = `PS2_KEY_EXTENDED;

  // Receiver to decoder
  scan_byte_t rx_byte;
  logic       rx_byte_valid;

  // Decoder broadcast to all slots
  logic       ev_valid;
  scan_byte_t ev_code;
  logic       ev_extended;
  logic       ev_make;

  // One pressed bit per slot
  key_vec_t   pressed;

  ps2_frame_rx u_frame_rx (
    .i_clk         (CLOCK_50),
    .i_reset_n     (reset),
    .i_ps2_clk     (i_ps2_clk),
    .i_ps2_dat     (i_ps2_dat),
    .o_byte        (rx_byte),
    .o_byte_valid  (rx_byte_valid),
    .o_frame_error (o_frame_error)
  );

  scan_code_decoder u_decoder (
    .i_clk            (CLOCK_50),
    .i_reset_n        (reset),
    .i_byte           (rx_byte),
    .i_byte_valid     (rx_byte_valid),
    .o_event_valid    (ev_valid),
    .o_event_code     (ev_code),
    .o_event_extended (ev_extended),
    .o_event_make     (ev_make)
  );

  // Slot g owns byte g of the code table
  for (genvar g = 0; g < `PS2_NUM_KEYS; g++) begin : g_slot
    key_slot #(
      .KEY_CODE     (KEY_CODES[8*g +: 8]),
      .KEY_EXTENDED (KEY_EXTENDED[g])
    ) u_slot (
      .i_clk            (CLOCK_50),
      .i_reset_n        (reset),
      .i_event_valid    (ev_valid),
      .i_event_code     (ev_code),
      .i_event_extended (ev_extended),
      .i_event_make     (ev_make),
      .o_pressed        (pressed[g])
    );
  end

  key_output_stage u_output (
    .i_clk        (CLOCK_50),
    .i_reset_n    (reset),
    .i_pressed    (pressed),
    .i_pulse_mode (i_pulse_mode),
    .o_keys       (o_keys)
  );

endmodule

`default_nettype wire

// ==== key_output_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_consts.svh"

module key_output_stage
  import ps2_kbd_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  key_vec_t i_pressed,
  input  logic     i_pulse_mode,
  output key_vec_t o_keys
);

  // Press vector delayed by one cycle
  key_vec_t lock;

  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      lock   <= '0;
      o_keys <= '0;
    end else begin
      for (int k = 0; k < `PS2_NUM_KEYS; k++) begin
        // Lock rises one cycle after the press bit
        lock[k] <= i_pressed[k];
        // Hold mode passes the press bit straight through
        // pulse mode only lets the first pressed cycle out
        o_keys[k] <= i_pressed[k] && !(i_pulse_mode && lock[k]);
      end
    end
  end

endmodule

`default_nettype wire

// ==== key_slot.sv ====
`timescale 1ns/1ns
`default_nettype none

module key_slot
  import ps2_kbd_pkg::*;
#(
  parameter scan_byte_t KEY_CODE     = 8'h00,
  parameter bit         KEY_EXTENDED = 1'b0
) (
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_event_valid,
  input  scan_byte_t i_event_code,
  input  logic       i_event_extended,
  input  logic       i_event_make,
  output logic       o_pressed
);

  logic hit;

  // Code and prefix must both match
  // so a bare 74 never hits the right arrow
  assign hit = i_event_valid
            && (i_event_code == KEY_CODE)
            && (i_event_extended == KEY_EXTENDED);

  // Pressed state of this key
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      o_pressed <= 1'b0;
    end else if (hit) begin
      // Make sets, break clears
      o_pressed <= i_event_make;
    end
  end

endmodule

`default_nettype wire

// ==== scan_code_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_consts.svh"

module scan_code_decoder
  import ps2_kbd_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  scan_byte_t i_byte,
  input  logic       i_byte_valid,
  output logic       o_event_valid,
  output scan_byte_t o_event_code,
  output logic       o_event_extended,
  output logic       o_event_make
);

  decode_state_t state;
  logic          state_ext;
  logic          state_make;

  // Flags of the code the current state is waiting for
  assign state_ext  = (state == EXT_MAKE) || (state == EXT_BREAK);
  assign state_make = (state == MAKE) || (state == EXT_MAKE);

  // Prefix FSM and event valid
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      state         <= MAKE;
      o_event_valid <= 1'b0;
    end else begin
      o_event_valid <= 1'b0;
      if (i_byte_valid) begin
        if (i_byte == `PS2_CODE_EXTEND) begin
          // E0 always opens an extended code
          state <= EXT_MAKE;
        end else if (i_byte == `PS2_CODE_BREAK) begin
          // F0 keeps the extended flag and turns it into a release
          state <= state_ext ? EXT_BREAK : BREAK;
        end else begin
          // Any other byte completes the code
          o_event_valid <= 1'b1;
          state         <= MAKE;
        end
      end
    end
  end

  // Event payload, qualified by o_event_valid
  always_ff @(posedge i_clk) begin
    if (i_byte_valid) begin
      o_event_code     <= i_byte;
      o_event_extended <= state_ext;
      o_event_make     <= state_make;
    end
  end

endmodule

`default_nettype wire

// ==== ps2_frame_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ps2_kbd_consts.svh"

module ps2_frame_rx
  import ps2_kbd_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_ps2_clk,
  input  logic       i_ps2_dat,
  output scan_byte_t o_byte,
  output logic       o_byte_valid,
  output logic       o_frame_error
);

  localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES);
  localparam int CNT_W  = $clog2(`PS2_FRAME_BITS);
  localparam int SYNC_MSB = `PS2_SYNC_STAGES - 1;

  // Synchroniser chains, newest sample at bit 0
  logic [SYNC_MSB:0] clk_sync;
  logic [SYNC_MSB:0] dat_sync;
  logic              clk_prev;
  logic              clk_fall;

  // Frame shift register, line bits enter at the top
  logic [`PS2_FRAME_BITS-1:0] shift_q;
  logic [`PS2_FRAME_BITS-1:0] frame_next;
  logic [CNT_W-1:0]           bit_cnt;
  logic [IDLE_W-1:0]          idle_cnt;
  logic                       last_bit;
  logic                       frame_ok;

  // Both lines idle high, so sync flops come out of reset high
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      clk_sync <= '1;
      dat_sync <= '1;
      clk_prev <= 1'b1;
    end else begin
      clk_sync <= {clk_sync[SYNC_MSB-1:0], i_ps2_clk};
      dat_sync <= {dat_sync[SYNC_MSB-1:0], i_ps2_dat};
      clk_prev <= clk_sync[SYNC_MSB];
    end
  end

  // Keyboard changes data on rising edge, we sample on the fall
  assign clk_fall = clk_prev & ~clk_sync[SYNC_MSB];

  // Shift in LSB first, so the finished frame has start at bit 0
  assign frame_next = {dat_sync[SYNC_MSB], shift_q[`PS2_FRAME_BITS-1:1]};
  assign last_bit   = (bit_cnt == CNT_W'(`PS2_FRAME_BITS - 1));

  // Start low, odd parity over data plus parity bit, stop high
  assign frame_ok = !frame_next[0]
                  && (^frame_next[9:1])
                  && frame_next[`PS2_FRAME_BITS-1];

  // Frame and byte payload
  always_ff @(posedge i_clk) begin
    if (clk_fall) begin
      shift_q <= frame_next;
    end
    if (clk_fall && last_bit) begin
      o_byte <= frame_next[8:1];
    end
  end

  // Bit counter, idle timeout and result pulses
  always_ff @(posedge i_clk) begin
    if (!i_reset_n) begin
      bit_cnt       <= '0;
      idle_cnt      <= '0;
      o_byte_valid  <= 1'b0;
      o_frame_error <= 1'b0;
    end else begin
      // Pulses last one cycle
      o_byte_valid  <= 1'b0;
      o_frame_error <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (last_bit) begin
          // Eleventh bit, frame complete
          bit_cnt       <= '0;
          o_byte_valid  <= frame_ok;
          o_frame_error <= !frame_ok;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else if (bit_cnt != '0) begin
        // Mid frame with a silent clock, drop it after the timeout
        if (idle_cnt == IDLE_W'(`PS2_IDLE_CYCLES - 1)) begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== ps2_kbd_pkg.sv ====
`default_nettype none

`include "ps2_kbd_consts.svh"

package ps2_kbd_pkg;

  // One scan code byte as sent by the keyboard
  typedef logic [7:0] scan_byte_t;

  // One bit per tracked key, same order as the code table
  typedef logic [`PS2_NUM_KEYS-1:0] key_vec_t;

  // Decoder prefix state
  // bit 1 marks extended, bit 0 marks break
  typedef enum logic [1:0] {
    MAKE      = 2'b00,
    BREAK     = 2'b01,
    EXT_MAKE  = 2'b10,
    EXT_BREAK = 2'b11
  } decode_state_t;

endpackage

`default_nettype wire

// ==== ps2_kbd_consts.svh ====
`ifndef PS2_KBD_CONSTS_SVH
`define PS2_KBD_CONSTS_SVH

// Frame timing

// Flops in each PS/2 line synchroniser
`define PS2_SYNC_STAGES 2

// Start, eight data bits, parity and stop
`define PS2_FRAME_BITS 11

// CLOCK_50 cycles with no PS/2 clock fall before a partial frame is dropped
`define PS2_IDLE_CYCLES 5000

// Scan Code Set 2 prefix bytes

// Extended key follows
`define PS2_CODE_EXTEND 8'he0

// Key release follows
`define PS2_CODE_BREAK 8'hf0

// Tracked keys

// Number of key slots
`define PS2_NUM_KEYS 8

// Key code table, one byte per key, index 0 in the lowest byte
// 0 left, 1 right, 2 up, 3 down
// 4 W, 5 A, 6 S, 7 D
`define PS2_KEY_CODES 64'h23_1b_1c_1d_72_75_74_6b

// Keys sent behind an E0 prefix, the four arrows
`define PS2_KEY_EXTENDED 8'h0f

`endif
